/* Makefile */
VERILATOR ?= verilator
TOP ?= cacheTb
FILELIST ?= verilog.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)

/* src/cacheArrays.sv */
`timescale 1ns/10ps
`default_nettype none

module cacheArrays
	import cachePkg::*;
(
	input logic clk,
	input logic reset,
	input logic [indexBits-1:0] lookupIndex,
	output logic [numWays-1:0][tagBits-1:0] setTags,
	output logic [numWays-1:0] setValid,
	output logic [numWays-1:0] setDirty,
	output logic setLru,
	output lineT [numWays-1:0] setLines,
	input arrayWriteS arrayWrite
);

	logic [tagBits-1:0] tagMem [numWays][numSets];
	lineT lineMem [numWays][numSets];
	logic [numWays-1:0][numSets-1:0] validBits;
	logic [numWays-1:0][numSets-1:0] dirtyBits;
	logic [numSets-1:0] lruBits; // names the least recently used way

	// combinational read of the whole set
	always_comb begin
		for (int w = 0; w < numWays; w++) begin
			setTags[w] = tagMem[w][lookupIndex];
			setLines[w] = lineMem[w][lookupIndex];
			setValid[w] = validBits[w][lookupIndex];
			setDirty[w] = dirtyBits[w][lookupIndex];
		end
		setLru = lruBits[lookupIndex];
	end

	always_ff @(posedge clk) begin
		if (arrayWrite.writeLine) begin
			tagMem[arrayWrite.way][arrayWrite.index] <= arrayWrite.tag;
			lineMem[arrayWrite.way][arrayWrite.index] <= arrayWrite.line;
			dirtyBits[arrayWrite.way][arrayWrite.index] <= arrayWrite.dirty;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			validBits <= '0;
			lruBits <= '0; // way 0 is the first victim
		end else begin
			if (arrayWrite.writeLine) begin
				validBits[arrayWrite.way][arrayWrite.index] <= 1'b1;
			end
			if (arrayWrite.touch) begin
				lruBits[arrayWrite.index] <= ~arrayWrite.way; // other way is now lru
			end
		end
	end

endmodule

`default_nettype wire

/* src/cacheController.sv */
`timescale 1ns/10ps
`default_nettype none

module cacheController
	import cachePkg::*;
(
	input logic clk,
	input logic reset,
	input cpuReqS cpuReq,
	input lookupResS lookupRes,
	output arrayWriteS arrayWrite,
	output logic done,
	output logic [wordBits-1:0] readData,
	output memReqS readReq,
	output logic memReadEnable,
	input logic memReadReady,
	input lineT fillLine,
	output memReqS writeReq,
	output logic memWriteEnable,
	input logic memWriteReady
);

	ctrlStateE state;
	logic lookupSettled;
	logic isWrite;
	logic [tagBits-1:0] reqTag;
	logic [indexBits-1:0] reqIndex;
	logic [wordSelBits-1:0] wordSel;
	logic checkNow;
	logic hitNow;
	logic fillNow;
	lineT mergedLine;

	assign isWrite = (lookupRes.req.cmd == cmdWrite);
	assign reqTag = lookupRes.req.addr[addrBits-1 -: tagBits];
	assign reqIndex = lookupRes.req.addr[offsetBits +: indexBits];
	assign wordSel = lookupRes.req.addr[offsetBits-1 -: wordSelBits];

	// second check cycle, lookup result belongs to the held request
	assign checkNow = (state == ctrlCheck) && lookupSettled;
	assign hitNow = checkNow && lookupRes.hit;
	assign fillNow = (state == ctrlWaitFill) && memReadReady;

	always_comb begin
		mergedLine = (state == ctrlWaitFill) ? fillLine : lookupRes.line;
		if (isWrite) begin
			mergedLine[wordSel] = lookupRes.req.writeData; // write allocate merge
		end
	end

	// lookup result holds steady during a miss, no array writes until the fill
	assign readReq.addr = {reqTag, reqIndex, {offsetBits{1'b0}}};
	assign readReq.line = '0;
	assign writeReq.addr = {lookupRes.victimTag, reqIndex, {offsetBits{1'b0}}};
	assign writeReq.line = lookupRes.line;

	always_comb begin
		arrayWrite.writeLine = (hitNow && isWrite) || fillNow;
		arrayWrite.index = reqIndex;
		arrayWrite.way = lookupRes.way;
		arrayWrite.tag = reqTag;
		arrayWrite.line = mergedLine;
		arrayWrite.dirty = isWrite;
		arrayWrite.touch = hitNow || fillNow; // every completed access
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrlIdle;
			lookupSettled <= 1'b0;
			done <= 1'b0;
			memReadEnable <= 1'b0;
			memWriteEnable <= 1'b0;
		end else begin
			done <= 1'b0;
			memReadEnable <= 1'b0;
			memWriteEnable <= 1'b0;
			case (state)
				ctrlIdle: begin
					// done still high means the old command is on the bus
					if (!done && cpuReq.cmd != cmdNone) begin
						state <= ctrlCheck;
					end
				end
				ctrlCheck: begin
					lookupSettled <= !lookupSettled;
					if (checkNow) begin
						if (lookupRes.hit) begin
							done <= 1'b1;
							state <= ctrlIdle;
						end else if (lookupRes.victimDirty) begin
							memWriteEnable <= 1'b1;
							state <= ctrlWriteBack;
						end else begin
							memReadEnable <= 1'b1;
							state <= ctrlRefill;
						end
					end
				end
				ctrlWriteBack: begin
					if (memWriteReady) begin
						memReadEnable <= 1'b1; // refill right after write-back
						state <= ctrlRefill;
					end
				end
				ctrlRefill: begin
					state <= ctrlWaitFill; // enable pulse is high here
				end
				ctrlWaitFill: begin
					if (memReadReady) begin
						done <= 1'b1;
						state <= ctrlIdle;
					end
				end
				default: begin
					state <= ctrlIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (hitNow || fillNow) begin
			readData <= mergedLine[wordSel];
		end
	end

endmodule

`default_nettype wire

/* src/cacheLookup.sv */
`timescale 1ns/10ps
`default_nettype none

module cacheLookup
	import cachePkg::*;
(
	input logic clk,
	input logic reset,
	input cpuReqS cpuReq,
	output logic [indexBits-1:0] lookupIndex,
	input logic [numWays-1:0][tagBits-1:0] setTags,
	input logic [numWays-1:0] setValid,
	input logic [numWays-1:0] setDirty,
	input logic setLru,
	input lineT [numWays-1:0] setLines,
	output lookupResS lookupRes
);

	logic [tagBits-1:0] reqTag;
	logic [numWays-1:0] wayHit;
	logic anyHit;
	logic selWay;
	lookupResS resNext;

	assign reqTag = cpuReq.addr[addrBits-1 -: tagBits];
	assign lookupIndex = cpuReq.addr[offsetBits +: indexBits];

	always_comb begin
		for (int w = 0; w < numWays; w++) begin
			wayHit[w] = setValid[w] && (setTags[w] == reqTag);
		end
	end

	assign anyHit = |wayHit;

	// tags in a set are unique, so at most one way hits
	assign selWay = anyHit ? wayHit[1] : setLru;

	always_comb begin
		resNext.req = cpuReq;
		resNext.hit = anyHit;
		resNext.way = selWay;
		resNext.victimDirty = !anyHit && setValid[selWay] && setDirty[selWay];
		resNext.victimTag = setTags[selWay];
		resNext.line = setLines[selWay];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lookupRes <= '0;
		end else begin
			lookupRes <= resNext; // refreshed every cycle
		end
	end

endmodule

`default_nettype wire

/* src/cachePkg.sv */
`default_nettype none

package cachePkg;

	localparam int wordBits = 32;
	localparam int addrBits = 32;
	localparam int wordsPerLine = 4;
	localparam int numSets = 16;
	localparam int numWays = 2;
	localparam int offsetBits = 4; // byte offset in a line
	localparam int wordSelBits = 2;
	localparam int indexBits = 4;
	localparam int tagBits = 24; // addrBits - indexBits - offsetBits

	typedef enum logic [1:0] {
		cmdNone,
		cmdRead,
		cmdWrite
	} cacheCmdE;

	typedef enum logic [2:0] {
		ctrlIdle,
		ctrlCheck,
		ctrlWriteBack,
		ctrlRefill,
		ctrlWaitFill
	} ctrlStateE;

	typedef logic [wordsPerLine-1:0][wordBits-1:0] lineT; // word 0 in the low bits

	typedef struct packed {
		cacheCmdE cmd;
		logic [addrBits-1:0] addr;
		logic [wordBits-1:0] writeData;
	} cpuReqS;

	typedef struct packed {
		cpuReqS req;
		logic hit;
		logic way; // hit way, else the victim
		logic victimDirty;
		logic [tagBits-1:0] victimTag;
		lineT line; // current line of that way
	} lookupResS;

	typedef struct packed {
		logic writeLine;
		logic [indexBits-1:0] index;
		logic way;
		logic [tagBits-1:0] tag;
		lineT line;
		logic dirty;
		logic touch; // way becomes most recently used
	} arrayWriteS;

	typedef struct packed {
		logic [addrBits-1:0] addr; // always line aligned
		lineT line;
	} memReqS;

endpackage

`default_nettype wire

/* src/cacheTop.sv */
`timescale 1ns/10ps
`default_nettype none

module cacheTop
	import cachePkg::*;
(
	input logic clk,
	input logic reset,
	input cpuReqS cpuReq,
	output logic done,
	output logic [wordBits-1:0] readData,
	output memReqS readReq,
	output logic memReadEnable,
	input logic memReadReady,
	input lineT fillLine,
	output memReqS writeReq,
	output logic memWriteEnable,
	input logic memWriteReady
);

	logic [indexBits-1:0] lookupIndex;
	logic [numWays-1:0][tagBits-1:0] setTags;
	logic [numWays-1:0] setValid;
	logic [numWays-1:0] setDirty;
	logic setLru;
	lineT [numWays-1:0] setLines;
	lookupResS lookupRes;
	arrayWriteS arrayWrite;

	cacheLookup i_cacheLookup (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.lookupIndex(lookupIndex),
		.setTags(setTags),
		.setValid(setValid),
		.setDirty(setDirty),
		.setLru(setLru),
		.setLines(setLines),
		.lookupRes(lookupRes)
	);

	cacheArrays i_cacheArrays (
		.clk(clk),
		.reset(reset),
		.lookupIndex(lookupIndex),
		.setTags(setTags),
		.setValid(setValid),
		.setDirty(setDirty),
		.setLru(setLru),
		.setLines(setLines),
		.arrayWrite(arrayWrite)
	);

	cacheController i_cacheController (
		.clk(clk),
		.reset(reset),
		.cpuReq(cpuReq),
		.lookupRes(lookupRes),
		.arrayWrite(arrayWrite),
		.done(done),
		.readData(readData),
		.readReq(readReq),
		.memReadEnable(memReadEnable),
		.memReadReady(memReadReady),
		.fillLine(fillLine),
		.writeReq(writeReq),
		.memWriteEnable(memWriteEnable),
		.memWriteReady(memWriteReady)
	);

endmodule

`default_nettype wire

/* tests/cacheTb.sv */
`timescale 1ns/10ps
`default_nettype none

module cacheTb
	import cachePkg::*;
();

	localparam int driveDelay = 1;
	localparam int hitEdges = 3; // drive edge to E0 plus two more
	localparam int doneTimeout = 100;
	localparam logic [wordBits-1:0] patternKey = 32'h5A5A0000;

	typedef struct packed {
		logic hit;
		logic [wordBits-1:0] word;
		logic [addrBits-1:0] fillAddr;
		logic wbValid;
		logic [addrBits-1:0] wbAddr;
		lineT wbLine;
	} expectS;

	logic clk;
	logic reset;
	cpuReqS cpuReq;
	logic done;
	logic [wordBits-1:0] readData;
	memReqS readReq;
	memReqS writeReq;
	logic memReadEnable;
	logic memReadReady;
	logic memWriteEnable;
	logic memWriteReady;
	lineT fillLine;
	int readCount;
	int writeCount;

	logic [31:0] lfsrState;
	expectS expQueue [$];
	lineT refMemory [logic [addrBits-1:0]];
	logic [tagBits-1:0] refTag [numSets][numWays];
	lineT refLines [numSets][numWays];
	logic refValid [numSets][numWays];
	logic refDirty [numSets][numWays];
	logic refLru [numSets]; // least recently used way
	int refReads;
	int refWriteBacks;
	int checksRun;
	int errorsSeen;
	int testNum;
	int testErrorsStart;

	cacheTop i_cacheTop (.*);

	memModel i_memModel (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
		return bits;
	endfunction

	function automatic lineT memLine(input logic [addrBits-1:0] lineAddr);
		lineT line;
		if (refMemory.exists(lineAddr)) begin
			return refMemory[lineAddr];
		end
		for (int w = 0; w < wordsPerLine; w++) begin
			line[w] = (lineAddr + 32'(4 * w)) ^ patternKey; // byte address of the word
		end
		return line;
	endfunction

	// expected outcome of one access and its model update
	function automatic expectS refAccess(input cacheCmdE cmd, input logic [addrBits-1:0] addr,
			input logic [wordBits-1:0] data);
		expectS e;
		logic [indexBits-1:0] idx;
		logic [tagBits-1:0] tag;
		logic [wordSelBits-1:0] sel;
		logic way;
		lineT line;
		idx = addr[offsetBits +: indexBits];
		tag = addr[addrBits-1 -: tagBits];
		sel = addr[offsetBits-1 -: wordSelBits];
		e = '0;
		way = refLru[idx];
		for (int w = 0; w < numWays; w++) begin
			if (refValid[idx][w] && refTag[idx][w] == tag) begin
				e.hit = 1'b1;
				way = w[0];
			end
		end
		if (e.hit) begin
			line = refLines[idx][way];
		end else begin
			if (refValid[idx][way] && refDirty[idx][way]) begin
				e.wbValid = 1'b1;
				e.wbAddr = {refTag[idx][way], idx, {offsetBits{1'b0}}};
				e.wbLine = refLines[idx][way];
				refMemory[e.wbAddr] = e.wbLine;
				refWriteBacks++;
			end
			e.fillAddr = {tag, idx, {offsetBits{1'b0}}};
			line = memLine(e.fillAddr);
			refReads++;
			refValid[idx][way] = 1'b1;
			refTag[idx][way] = tag;
			refDirty[idx][way] = 1'b0;
		end
		if (cmd == cmdWrite) begin
			line[sel] = data;
			refDirty[idx][way] = 1'b1;
		end
		refLines[idx][way] = line;
		refLru[idx] = ~way;
		e.word = line[sel];
		return e;
	endfunction

	task automatic checkWord(input string what, input logic [wordBits-1:0] got,
			input logic [wordBits-1:0] exp);
		checksRun++;
		if (got !== exp) begin
			errorsSeen++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkAddr(input string what, input logic [addrBits-1:0] got,
			input logic [addrBits-1:0] exp);
		checksRun++;
		if (got !== exp) begin
			errorsSeen++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkLine(input string what, input lineT got, input lineT exp);
		checksRun++;
		if (got !== exp) begin
			errorsSeen++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkCount(input string what, input int got, input int exp);
		checksRun++;
		if (got != exp) begin
			errorsSeen++;
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic nextEdge();
		@(posedge clk);
		#driveDelay;
	endtask

	task automatic runAccess(input cacheCmdE cmd, input logic [addrBits-1:0] addr,
			input logic [wordBits-1:0] data);
		expectS e;
		int edges;
		e = refAccess(cmd, addr, data);
		nextEdge();
		cpuReq.cmd = cmd;
		cpuReq.addr = addr;
		cpuReq.writeData = data;
		expQueue.push_back(e);
		edges = 0;
		do begin
			nextEdge();
			edges++;
		end while (done !== 1'b1 && edges < doneTimeout);
		if (done !== 1'b1) begin
			errorsSeen++;
			$display("no done within %0d cycles for address %h", doneTimeout, addr);
		end else if (e.hit) begin
			checkCount("hit latency in edges", edges, hitEdges);
		end
		cpuReq.cmd = cmdNone;
	endtask

	task automatic endTest(input string name);
		nextEdge(); // lets the compare process finish the last access
		testNum++;
		$display("test %0d %s: %0d errors", testNum, name, errorsSeen - testErrorsStart);
		testErrorsStart = errorsSeen;
	endtask

	initial begin : compareDone
		expectS e;
		int seenReads;
		int seenWrites;
		seenReads = 0;
		seenWrites = 0;
		forever begin
			nextEdge();
			if (done === 1'b1 && expQueue.size() == 0) begin
				errorsSeen++;
				$display("done pulse at %0t with no request outstanding", $time);
			end else if (done === 1'b1) begin
				e = expQueue.pop_front();
				checkWord("readData", readData, e.word);
				checkCount("memory reads", readCount - seenReads, e.hit ? 0 : 1);
				checkCount("write-backs", writeCount - seenWrites, e.wbValid ? 1 : 0);
				if (!e.hit && readCount > seenReads) begin
					checkAddr("refill address", i_memModel.readAddrLog[readCount-1], e.fillAddr);
				end
				if (e.wbValid && writeCount > seenWrites && readCount > seenReads) begin
					checkAddr("write-back address", i_memModel.writeAddrLog[writeCount-1],
						e.wbAddr);
					checkLine("write-back line", i_memModel.writeLineLog[writeCount-1], e.wbLine);
					if (i_memModel.writeTimeLog[writeCount-1] >=
							i_memModel.readTimeLog[readCount-1]) begin
						errorsSeen++;
						$display("write-back at %0t did not come before the refill", $time);
					end
				end
				seenReads = readCount;
				seenWrites = writeCount;
			end
		end
	end

	initial begin
		logic [addrBits-1:0] addr;
		logic [3:0] tagSel;
		logic [1:0] setSel;
		logic [1:0] wordSel;
		int readsAtStart;
		int writesAtStart;
		cpuReq = '0;
		reset = 1'b1;
		lfsrState = 32'd62;
		refReads = 0;
		refWriteBacks = 0;
		checksRun = 0;
		errorsSeen = 0;
		testNum = 0;
		testErrorsStart = 0;
		for (int s = 0; s < numSets; s++) begin
			refLru[s] = 1'b0;
			for (int w = 0; w < numWays; w++) begin
				refValid[s][w] = 1'b0;
				refDirty[s][w] = 1'b0;
			end
		end
		repeat (3) @(posedge clk);
		#driveDelay;
		reset = 1'b0;

		checksRun++;
		if (done !== 1'b0 || memReadEnable !== 1'b0 || memWriteEnable !== 1'b0) begin
			errorsSeen++;
			$display("FAIL %0t: done or a memory enable is not low after reset", $time);
		end
		runAccess(cmdRead, 32'h0000_1234, '0);
		runAccess(cmdRead, 32'h0004_5678, '0);
		endTest("first reads miss");

		runAccess(cmdRead, 32'h0000_1234, '0);
		runAccess(cmdRead, 32'h0000_1238, '0); // other word, same line
		runAccess(cmdRead, 32'h0004_567C, '0);
		endTest("read hits");

		runAccess(cmdWrite, 32'h0000_1230, 32'hC0FF_EE01);
		runAccess(cmdRead, 32'h0000_1230, '0);
		runAccess(cmdWrite, 32'h0009_9944, 32'h1357_9BDF); // write allocate
		runAccess(cmdRead, 32'h0009_9944, '0);
		runAccess(cmdRead, 32'h0009_9940, '0);
		endTest("write hit and write miss");

		runAccess(cmdRead, 32'h00A0_0090, '0);
		runAccess(cmdWrite, 32'h00B0_0094, 32'hB0B0_0001);
		runAccess(cmdRead, 32'h00A0_0090, '0);
		runAccess(cmdRead, 32'h00C0_0098, '0); // evicts the dirty line
		runAccess(cmdWrite, 32'h00C0_009C, 32'hC0C0_0002);
		runAccess(cmdRead, 32'h00D0_009C, '0);
		runAccess(cmdRead, 32'h00B0_0094, '0);
		endTest("lru eviction with write-back");

		readsAtStart = readCount;
		writesAtStart = writeCount;
		refReads = 0;
		refWriteBacks = 0;
		for (int i = 0; i < 200; i++) begin
			tagSel = 4'(takeBits(4) % 12);
			setSel = 2'(takeBits(2));
			wordSel = 2'(takeBits(2));
			addr = {20'h7E5C3, tagSel, 2'b00, setSel, wordSel, 2'b00};
			if (takeBits(1) == 32'd1) begin
				runAccess(cmdWrite, addr, takeBits(32));
			end else begin
				runAccess(cmdRead, addr, '0);
			end
		end
		nextEdge();
		checkCount("memory reads in random run", readCount - readsAtStart, refReads);
		checkCount("write-backs in random run", writeCount - writesAtStart, refWriteBacks);
		endTest("random accesses");

		$display("%0d tests, %0d checks, %0d errors", testNum, checksRun, errorsSeen);
		if (errorsSeen == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/memModel.sv */
`timescale 1ns/10ps
`default_nettype none

module memModel
	import cachePkg::*;
(
	input logic clk,
	input memReqS readReq,
	input logic memReadEnable,
	output logic memReadReady,
	output lineT fillLine,
	input memReqS writeReq,
	input logic memWriteEnable,
	output logic memWriteReady,
	output int readCount,
	output int writeCount
);

	localparam int driveDelay = 1;
	localparam int logDepth = 512;
	localparam logic [wordBits-1:0] patternKey = 32'h5A5A0000;

	lineT written [logic [addrBits-1:0]]; // write-back lines by line address
	logic [addrBits-1:0] readAddrLog [logDepth];
	logic [addrBits-1:0] writeAddrLog [logDepth];
	lineT writeLineLog [logDepth];
	time readTimeLog [logDepth];
	time writeTimeLog [logDepth];
	logic [31:0] lfsrState;

	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	function automatic int pickLatency();
		int latency;
		latency = 0;
		for (int i = 0; i < 3; i++) begin
			latency = (latency << 1) | int'(lfsrState[0]);
			lfsrState = lfsrStep(lfsrState);
		end
		return latency + 1; // 1 to 8 cycles
	endfunction

	function automatic lineT lineContents(input logic [addrBits-1:0] lineAddr);
		lineT line;
		if (written.exists(lineAddr)) begin
			return written[lineAddr];
		end
		for (int w = 0; w < wordsPerLine; w++) begin
			line[w] = (lineAddr + 32'(4 * w)) ^ patternKey;
		end
		return line;
	endfunction

	task automatic serveRead();
		int latency;
		logic [addrBits-1:0] addr;
		addr = readReq.addr;
		latency = pickLatency();
		if (readCount < logDepth) begin
			readAddrLog[readCount] = addr;
			readTimeLog[readCount] = $time;
		end
		readCount++;
		repeat (latency) begin
			@(posedge clk);
			#driveDelay;
		end
		fillLine = lineContents(addr);
		memReadReady = 1'b1;
	endtask

	task automatic serveWrite();
		int latency;
		latency = pickLatency();
		if (writeCount < logDepth) begin
			writeAddrLog[writeCount] = writeReq.addr;
			writeLineLog[writeCount] = writeReq.line;
			writeTimeLog[writeCount] = $time;
		end
		written[writeReq.addr] = writeReq.line;
		writeCount++;
		repeat (latency) begin
			@(posedge clk);
			#driveDelay;
		end
		memWriteReady = 1'b1;
	endtask

	initial begin
		memReadReady = 1'b0;
		memWriteReady = 1'b0;
		fillLine = '0;
		readCount = 0;
		writeCount = 0;
		lfsrState = 32'd62;
		forever begin
			@(posedge clk);
			#driveDelay;
			memReadReady = 1'b0; // ready pulses last one cycle
			memWriteReady = 1'b0;
			if (memWriteEnable) begin
				serveWrite();
			end else if (memReadEnable) begin
				serveRead();
			end
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
src/cachePkg.sv
src/cacheLookup.sv
src/cacheArrays.sv
src/cacheController.sv
src/cacheTop.sv
tests/memModel.sv
tests/cacheTb.sv
